/* Bender.yml */
package:
  name: adc_acq

sources:
  - include_dirs:
      - src
    files:
      - src/adc_acq_pkg.sv
      - src/conv_sequencer.sv
      - src/ad4003_lane.sv
      - src/sample_packer.sv
      - src/adc_acq_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/adc_acq_tb.sv

/* dv/adc_acq_tb.sv */
// ADC acquisition testbench: serial AD4003 model, stream reference model and checks
`timescale 1ns/10ps
`include "adc_acq_config.svh"

module adc_acq_tb;

   localparam int CH           = `ADC_CHANNELS;
   localparam int DW           = `ADC_DATA_WIDTH;
   localparam int SW           = `SLOT_WIDTH;
   localparam int SLOTS        = `SLOTS_PER_WORD;
   localparam int WORDS        = `WORDS_PER_FRAME;
   localparam int RAND_FRAMES  = 6;      // random ready stalls
   localparam int HOLD_FRAMES  = 3;      // ready held low
   localparam int POST_FRAMES  = 3;      // drain after the hold
   localparam int RST_FRAMES   = 4;      // after mid-run reset
   localparam int TOTAL_FRAMES = RAND_FRAMES + HOLD_FRAMES + POST_FRAMES + RST_FRAMES;
   localparam int CYCLE_LIMIT  = TOTAL_FRAMES * `FRAME_CYCLES * 4 + 200;

   logic                      adc_read_clk;
   logic                      control_reg_i;
   logic                      soft_trig_i;
   logic [`ADC_MODULES-1:0]   adc_sdo_cha_i;
   logic [`ADC_MODULES-1:0]   adc_sdo_chb_i;
   logic                      m_axis_tready_i;
   logic                      acq_on_o;
   logic                      adc_cnvst_o;
   logic                      adc_sck_o;
   logic [`STREAM_WIDTH-1:0]  m_axis_tdata_o;
   logic                      m_axis_tvalid_o;
   logic                      m_axis_tlast_o;
   logic                      overflow_o;

   // reference model state
   logic [31:0]               rng_state;
   logic [CH*DW-1:0]          exp_frames[$];     // samples per converted frame
   logic [7:0]                exp_seqs[$];       // matching frame numbers
   logic [DW-1:0]             cur_samp[CH];      // frame being serialized
   logic [7:0]                frame_no;
   logic [`STREAM_WIDTH-1:0]  held_data;
   logic                      cnv_prev;          // convert level one step back
   logic                      hold_pending;
   logic                      held_last;
   logic                      expect_zero;       // first frame after restart
   int                        cycle_cnt;
   int                        last_cnv;          // cycle of the last convert rise
   int                        bit_pos;
   int                        word_idx;
   int                        frames_rx;
   int                        skipped;
   int                        ready_mode;        // 0 random, 1 held low
   int                        ovf_rule;          // 0 must be low, 1 free, 2 must be high

   adc_acq_top adc_acq_top_inst (
      .adc_read_clk   (adc_read_clk),
      .control_reg_i  (control_reg_i),
      .soft_trig_i    (soft_trig_i),
      .adc_sdo_cha_i  (adc_sdo_cha_i),
      .adc_sdo_chb_i  (adc_sdo_chb_i),
      .m_axis_tready_i(m_axis_tready_i),
      .acq_on_o       (acq_on_o),
      .adc_cnvst_o    (adc_cnvst_o),
      .adc_sck_o      (adc_sck_o),
      .m_axis_tdata_o (m_axis_tdata_o),
      .m_axis_tvalid_o(m_axis_tvalid_o),
      .m_axis_tlast_o (m_axis_tlast_o),
      .overflow_o     (overflow_o)
   );

   initial begin
      adc_read_clk = 1'b0;
      forever #5 adc_read_clk = ~adc_read_clk;   // 100 MHz
   end

   // **************************************************
   // helpers
   // **************************************************
   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         $display("error: %s got %h expected %h", name, got, exp);
         $display("Verification failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic abort(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "run aborted");
   endtask

   task automatic clear_model();
      exp_frames.delete();
      exp_seqs.delete();
      frame_no     = '0;
      last_cnv     = -1;
      bit_pos      = 0;
      word_idx     = 0;
      cnv_prev     = 1'b0;
      hold_pending = 1'b0;
      ovf_rule     = 0;
   endtask

   // serial ADC: new samples per convert pulse, msb first while sck is high
   task automatic adc_model();
      logic [CH*DW-1:0] frame;
      if (adc_cnvst_o && !cnv_prev) begin
         if (last_cnv >= 0)
            check_val("adc_cnvst_o period", cycle_cnt - last_cnv, `FRAME_CYCLES);
         last_cnv = cycle_cnt;
         for (int c = 0; c < CH; c++) begin
            cur_samp[c]       = DW'(xorshift());
            frame[c*DW +: DW] = cur_samp[c];
         end
         exp_frames.push_back(frame);
         exp_seqs.push_back(frame_no);
         frame_no = frame_no + 1'b1;   // every convert is a frame
         bit_pos  = 0;
      end
      cnv_prev = adc_cnvst_o;
      if (adc_sck_o && bit_pos >= DW)
         abort("serial clock ran for more bits than one sample holds");
      if (adc_sck_o) begin
         for (int m = 0; m < `ADC_MODULES; m++) begin
            adc_sdo_cha_i[m] = cur_samp[2*m][DW-1-bit_pos];     // channel 2m
            adc_sdo_chb_i[m] = cur_samp[2*m+1][DW-1-bit_pos];   // channel 2m+1
         end
         bit_pos++;
      end
   endtask

   task automatic drive_ready();
      logic [31:0] rnd;
      rnd = xorshift();
      m_axis_tready_i = (ready_mode == 1) ? 1'b0 : rnd[0];
   endtask

   // stream monitor, word transfers at the coming rising edge
   task automatic check_stream();
      logic [CH*DW-1:0] frame;
      logic [7:0]       seq;
      logic [SW-1:0]    slot;
      int               ch;
      if (hold_pending) begin                 // stalled word must not move
         check_val("m_axis_tvalid_o", m_axis_tvalid_o, 1);
         check_val("m_axis_tdata_o", m_axis_tdata_o, held_data);
         check_val("m_axis_tlast_o", m_axis_tlast_o, held_last);
      end
      if (!m_axis_tvalid_o)
         check_val("m_axis_tlast_o", m_axis_tlast_o, 0);
      hold_pending = m_axis_tvalid_o && !m_axis_tready_i;
      held_data    = m_axis_tdata_o;
      held_last    = m_axis_tlast_o;
      if (m_axis_tvalid_o && m_axis_tready_i) begin
         seq = m_axis_tdata_o[31:24];
         if (word_idx == 0) begin
            while (exp_seqs.size() > 0 && exp_seqs[0] != seq) begin
               check_val("overflow_o", overflow_o, 1);   // skip only after a drop
               void'(exp_seqs.pop_front());
               void'(exp_frames.pop_front());
               skipped++;
            end
            if (exp_seqs.size() == 0)
               abort("stream delivered a frame that the ADC model never converted");
            if (expect_zero)
               check_val("m_axis_tdata_o frame after restart", seq, 0);
            expect_zero = 1'b0;
         end
         frame = exp_frames[0];
         for (int k = 0; k < SLOTS; k++) begin
            ch   = word_idx * SLOTS + k;
            slot = m_axis_tdata_o[k*SW +: SW];
            check_val("m_axis_tdata_o sample", slot[DW-1:0], frame[ch*DW +: DW]);
            check_val("m_axis_tdata_o channel", slot[23:18], ch);
            check_val("m_axis_tdata_o frame", slot[31:24], exp_seqs[0]);
         end
         check_val("m_axis_tlast_o", m_axis_tlast_o, word_idx == WORDS - 1);
         if (word_idx == WORDS - 1) begin
            void'(exp_seqs.pop_front());
            void'(exp_frames.pop_front());
            frames_rx++;
            word_idx = 0;
         end else begin
            word_idx++;
         end
      end
   endtask

   // one cycle, all driving at the falling edge
   task automatic step();
      @(negedge adc_read_clk);
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT)
         abort($sformatf("timeout: frames still missing after %0d cycles", cycle_cnt));
      adc_model();
      drive_ready();
      check_stream();
      if (ovf_rule == 0)
         check_val("overflow_o", overflow_o, 0);
      else if (ovf_rule == 2)
         check_val("overflow_o", overflow_o, 1);   // sticky
   endtask

   task automatic check_idle();
      check_val("acq_on_o", acq_on_o, 0);
      check_val("adc_cnvst_o", adc_cnvst_o, 0);
      check_val("adc_sck_o", adc_sck_o, 0);
      check_val("m_axis_tvalid_o", m_axis_tvalid_o, 0);
   endtask

   task automatic reset_dut();
      control_reg_i = 1'b0;       // async clear
      soft_trig_i   = 1'b0;
      clear_model();
      repeat (4) begin
         step();
         check_idle();
      end
      control_reg_i = 1'b1;
   endtask

   // acq_on two edges after the trigger, first convert one cycle later
   task automatic trigger();
      logic [31:0] rnd;
      rnd = xorshift();
      repeat (2 + rnd[2:0]) step();
      soft_trig_i = 1'b1;
      step();
      check_val("acq_on_o", acq_on_o, 0);
      step();
      check_val("acq_on_o", acq_on_o, 1);
      check_val("adc_cnvst_o", adc_cnvst_o, 0);
      step();
      check_val("adc_cnvst_o", adc_cnvst_o, 1);
   endtask

   task automatic wait_frames(input int n);
      int target;
      target = frames_rx + n;
      while (frames_rx < target)
         step();
   endtask

   // **************************************************
   // test sequence
   // **************************************************
   initial begin
      rng_state       = 32'h9d2c_5713;
      control_reg_i   = 1'b0;
      soft_trig_i     = 1'b0;
      adc_sdo_cha_i   = '0;
      adc_sdo_chb_i   = '0;
      m_axis_tready_i = 1'b0;
      cycle_cnt       = 0;
      frames_rx       = 0;
      skipped         = 0;
      expect_zero     = 1'b0;
      ready_mode      = 0;
      reset_dut();
      repeat (10) begin
         step();
         check_idle();              // nothing moves before the trigger
      end
      trigger();
      wait_frames(RAND_FRAMES);
      ready_mode = 1;               // sink stalls past a frame
      ovf_rule   = 1;
      repeat (HOLD_FRAMES * `FRAME_CYCLES - 16) step();
      check_val("overflow_o", overflow_o, 1);
      ready_mode = 0;
      ovf_rule   = 2;
      wait_frames(POST_FRAMES);
      if (skipped == 0)
         abort("ready was held low past a frame but no dropped frame was seen");
      repeat (5 + xorshift() % 16) step();   // cut in mid-frame
      reset_dut();
      expect_zero = 1'b1;
      trigger();
      wait_frames(RST_FRAMES);
      $display("Verification passed");
      $finish;
   end

endmodule

/* files.f */
+incdir+src
src/adc_acq_pkg.sv
src/conv_sequencer.sv
src/ad4003_lane.sv
src/sample_packer.sv
src/adc_acq_top.sv
dv/adc_acq_tb.sv

/* src/ad4003_lane.sv */
// AD4003 dual channel lane: two serial shift registers and the held sample pair
`timescale 1ns/10ps
`include "adc_acq_config.svh"

module ad4003_lane (
   input  logic                     adc_read_clk,
   input  logic                     control_reg_i,
   input  logic                     bit_en_i,      // one bit per enabled edge
   input  logic                     sdo_cha_i,     // channel A serial data
   input  logic                     sdo_chb_i,     // channel B serial data
   output adc_acq_pkg::adc_sample_t sample_a_o,
   output adc_acq_pkg::adc_sample_t sample_b_o
);
   import adc_acq_pkg::*;

   localparam int BIT_CNT_W = $clog2(`ADC_DATA_WIDTH);
   localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(`ADC_DATA_WIDTH - 1);

   // the final bit goes straight into the hold register
   logic [`ADC_DATA_WIDTH-2:0] shift_a;
   logic [`ADC_DATA_WIDTH-2:0] shift_b;
   logic [BIT_CNT_W-1:0]       bit_cnt;
   logic                       last_bit;

   assign last_bit = bit_en_i && (bit_cnt == LAST_BIT);   // 18th edge

   // msb first shift
   always_ff @(posedge adc_read_clk) begin
      if (bit_en_i) begin
         shift_a <= {shift_a[`ADC_DATA_WIDTH-3:0], sdo_cha_i};
         shift_b <= {shift_b[`ADC_DATA_WIDTH-3:0], sdo_chb_i};
      end
   end

   // bits received in this frame
   always_ff @(posedge adc_read_clk or negedge control_reg_i) begin
      if (!control_reg_i)
         bit_cnt <= '0;
      else if (last_bit)
         bit_cnt <= '0;
      else if (bit_en_i)
         bit_cnt <= bit_cnt + 1'b1;
   end

   // completed pair, stable while the next frame shifts in
   always_ff @(posedge adc_read_clk) begin
      if (last_bit) begin
         sample_a_o <= adc_sample_t'({shift_a, sdo_cha_i});
         sample_b_o <= adc_sample_t'({shift_b, sdo_chb_i});
      end
   end

   // the sequencer burst never outruns one sample
   a_burst_len: assert property (@(posedge adc_read_clk) disable iff (!control_reg_i)
      $rose(bit_en_i) |-> ##[1:`ADC_DATA_WIDTH] !bit_en_i);

endmodule

/* src/adc_acq_config.svh */
// ADC acquisition configuration: channel count, data widths and frame timing
`ifndef ADC_ACQ_CONFIG_SVH
`define ADC_ACQ_CONFIG_SVH

// **************************************************
// channel layout
// **************************************************
`define ADC_CHANNELS      8                     // total channels, must be even
`define ADC_MODULES       (`ADC_CHANNELS / 2)   // dual channel AD4003 modules
`define ADC_DATA_WIDTH    18                    // bits per conversion

// **************************************************
// stream word layout
// **************************************************
`define STREAM_WIDTH      128                   // c2h word
`define SLOT_WIDTH        32                    // one sample slot
`define SLOTS_PER_WORD    4
`define WORDS_PER_FRAME   (`ADC_CHANNELS / `SLOTS_PER_WORD)

// **************************************************
// frame timing in adc_read_clk cycles
// **************************************************
`define FRAME_CYCLES      32                    // one conversion frame
`define CNV_CYCLES        4                     // convert start width
`define SCK_START         8                     // first serial bit

`endif

/* src/adc_acq_pkg.sv */
// ADC acquisition types shared by the sequencer, lanes, packer and top level
`include "adc_acq_config.svh"

package adc_acq_pkg;

   // one AD4003 result
   typedef logic [`ADC_DATA_WIDTH-1:0] adc_sample_t;

   // slot fields next to the sample
   typedef logic [5:0] chan_idx_t;        // up to 64 channels
   typedef logic [7:0] frame_seq_t;       // wraps every 256 frames

   // outgoing stream word
   typedef logic [`STREAM_WIDTH-1:0] stream_word_t;

   // position inside a frame
   typedef logic [$clog2(`FRAME_CYCLES)-1:0] frame_cnt_t;

   // conversion sequencer phases
   typedef enum logic [2:0] {
      SEQ_IDLE,      // waiting for acq_on
      SEQ_CONVERT,   // cnvst high
      SEQ_WAIT,      // conversion time
      SEQ_SHIFT,     // serial bits
      SEQ_DONE       // frame tail
   } seq_state_t;

   // packer buffer state
   typedef enum logic {
      PACK_EMPTY,
      PACK_SEND
   } pack_state_t;

endpackage

/* src/adc_acq_top.sv */
// ADC acquisition top level: sequencer, AD4003 lanes and stream packer
`timescale 1ns/10ps
`include "adc_acq_config.svh"

module adc_acq_top (
   input  logic                      adc_read_clk,
   input  logic                      control_reg_i,   // acquisition enable
   input  logic                      soft_trig_i,
   input  logic [`ADC_MODULES-1:0]   adc_sdo_cha_i,
   input  logic [`ADC_MODULES-1:0]   adc_sdo_chb_i,
   input  logic                      m_axis_tready_i,
   output logic                      acq_on_o,
   output logic                      adc_cnvst_o,
   output logic                      adc_sck_o,
   output adc_acq_pkg::stream_word_t m_axis_tdata_o,
   output logic                      m_axis_tvalid_o,
   output logic                      m_axis_tlast_o,
   output logic                      overflow_o
);
   import adc_acq_pkg::*;

   logic                            bit_en;       // shared by all lanes
   logic                            frame_done;
   adc_sample_t [`ADC_CHANNELS-1:0] samples;      // module m gives 2m and 2m+1

   conv_sequencer conv_sequencer_inst (
      .adc_read_clk (adc_read_clk),
      .control_reg_i(control_reg_i),
      .soft_trig_i  (soft_trig_i),
      .acq_on_o     (acq_on_o),
      .adc_cnvst_o  (adc_cnvst_o),
      .adc_sck_o    (adc_sck_o),
      .bit_en_o     (bit_en),
      .frame_done_o (frame_done)
   );

   // one lane per dual channel ADC
   for (genvar m = 0; m < `ADC_MODULES; m++) begin : g_lane
      ad4003_lane ad4003_lane_inst (
         .adc_read_clk (adc_read_clk),
         .control_reg_i(control_reg_i),
         .bit_en_i     (bit_en),
         .sdo_cha_i    (adc_sdo_cha_i[m]),
         .sdo_chb_i    (adc_sdo_chb_i[m]),
         .sample_a_o   (samples[2*m]),     // even channel
         .sample_b_o   (samples[2*m+1])    // odd channel
      );
   end

   sample_packer sample_packer_inst (
      .adc_read_clk   (adc_read_clk),
      .control_reg_i  (control_reg_i),
      .frame_done_i   (frame_done),
      .samples_i      (samples),
      .m_axis_tready_i(m_axis_tready_i),
      .m_axis_tdata_o (m_axis_tdata_o),
      .m_axis_tvalid_o(m_axis_tvalid_o),
      .m_axis_tlast_o (m_axis_tlast_o),
      .overflow_o     (overflow_o)
   );

endmodule

/* src/conv_sequencer.sv */
// Conversion sequencer: soft trigger capture and per-frame AD4003 convert and serial clock
`timescale 1ns/10ps
`include "adc_acq_config.svh"

module conv_sequencer (
   input  logic adc_read_clk,
   input  logic control_reg_i,    // acquisition enable, low clears
   input  logic soft_trig_i,
   output logic acq_on_o,
   output logic adc_cnvst_o,
   output logic adc_sck_o,
   output logic bit_en_o,         // to every lane
   output logic frame_done_o      // to packer
);
   import adc_acq_pkg::*;

   // phase boundaries, last count of each phase
   localparam frame_cnt_t CNV_LAST   = frame_cnt_t'(`CNV_CYCLES - 1);
   localparam frame_cnt_t WAIT_LAST  = frame_cnt_t'(`SCK_START - 1);
   localparam frame_cnt_t SHIFT_LAST = frame_cnt_t'(`SCK_START + `ADC_DATA_WIDTH - 1);
   localparam frame_cnt_t FRAME_LAST = frame_cnt_t'(`FRAME_CYCLES - 1);

   logic [1:0] soft_trig_dly;       // [0] newer, [1] older
   seq_state_t state_q, state_d;
   frame_cnt_t cnt_q, cnt_d;

   // **************************************************
   // trigger edge and acquisition flag
   // **************************************************
   always_ff @(posedge adc_read_clk or negedge control_reg_i) begin
      if (!control_reg_i) begin
         soft_trig_dly <= 2'b11;    // a level already high is no edge
         acq_on_o      <= 1'b0;
      end else begin
         soft_trig_dly <= {soft_trig_dly[0], soft_trig_i};
         if (soft_trig_dly == 2'b01)
            acq_on_o <= 1'b1;       // sticky until enable drops
      end
   end

   // **************************************************
   // frame state machine
   // **************************************************
   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q + 1'b1;
      case (state_q)
         SEQ_IDLE: begin
            cnt_d = '0;
            if (acq_on_o)
               state_d = SEQ_CONVERT;   // count 0 of first frame
         end
         SEQ_CONVERT: if (cnt_q == CNV_LAST)   state_d = SEQ_WAIT;
         SEQ_WAIT:    if (cnt_q == WAIT_LAST)  state_d = SEQ_SHIFT;
         SEQ_SHIFT:   if (cnt_q == SHIFT_LAST) state_d = SEQ_DONE;
         SEQ_DONE: begin
            if (cnt_q == FRAME_LAST) begin
               state_d = SEQ_CONVERT;   // back to back frames
               cnt_d   = '0;
            end
         end
         default: begin
            state_d = SEQ_IDLE;
            cnt_d   = '0;
         end
      endcase
   end

   // outputs registered from the next phase so they line up with cnt_q
   always_ff @(posedge adc_read_clk or negedge control_reg_i) begin
      if (!control_reg_i) begin
         state_q      <= SEQ_IDLE;
         cnt_q        <= '0;
         adc_cnvst_o  <= 1'b0;
         adc_sck_o    <= 1'b0;
         bit_en_o     <= 1'b0;
         frame_done_o <= 1'b0;
      end else begin
         state_q      <= state_d;
         cnt_q        <= cnt_d;
         adc_cnvst_o  <= (state_d == SEQ_CONVERT);
         adc_sck_o    <= (state_d == SEQ_SHIFT);   // pad copy
         bit_en_o     <= (state_d == SEQ_SHIFT);   // lane copy
         frame_done_o <= (state_d == SEQ_DONE) && (state_q != SEQ_DONE);
      end
   end

   // readout only after the conversion wait, never during convert
   a_cnv_sck_excl: assert property (@(posedge adc_read_clk) disable iff (!control_reg_i)
      adc_sck_o |-> !adc_cnvst_o && (cnt_q > WAIT_LAST));

   // one packer capture per frame, right after the last serial bit
   a_done_pulse: assert property (@(posedge adc_read_clk) disable iff (!control_reg_i)
      frame_done_o |-> (cnt_q == SHIFT_LAST + 1'b1) ##1 !frame_done_o);

endmodule

/* src/sample_packer.sv */
// Sample packer: frame capture from all lanes into 128-bit stream words with overflow flag
`timescale 1ns/10ps
`include "adc_acq_config.svh"

module sample_packer (
   input  logic                                         adc_read_clk,
   input  logic                                         control_reg_i,
   input  logic                                         frame_done_i,   // all lanes hold
   input  adc_acq_pkg::adc_sample_t [`ADC_CHANNELS-1:0] samples_i,
   input  logic                                         m_axis_tready_i,
   output adc_acq_pkg::stream_word_t                    m_axis_tdata_o,
   output logic                                         m_axis_tvalid_o,
   output logic                                         m_axis_tlast_o,
   output logic                                         overflow_o      // sticky
);
   import adc_acq_pkg::*;

   localparam int WIDX_W  = (`WORDS_PER_FRAME > 1) ? $clog2(`WORDS_PER_FRAME) : 1;
   localparam int SLOT_W  = `SLOT_WIDTH;
   localparam int SLOTS   = `SLOTS_PER_WORD;
   localparam logic [WIDX_W-1:0] LAST_WORD = WIDX_W'(`WORDS_PER_FRAME - 1);

   pack_state_t                        state_q;
   logic [WIDX_W-1:0]                  word_idx;      // word being offered
   frame_seq_t                         frame_seq_q;   // counts every finished frame
   frame_seq_t                         buf_seq;       // number of the buffered frame
   adc_sample_t [`ADC_CHANNELS-1:0]    frame_buf;
   logic                               capture;

   assign capture = frame_done_i && (state_q == PACK_EMPTY);

   // **************************************************
   // control and handshake
   // **************************************************
   always_ff @(posedge adc_read_clk or negedge control_reg_i) begin
      if (!control_reg_i) begin
         state_q     <= PACK_EMPTY;
         word_idx    <= '0;
         frame_seq_q <= '0;
         overflow_o  <= 1'b0;
      end else begin
         if (frame_done_i) begin
            frame_seq_q <= frame_seq_q + 1'b1;   // dropped frames still count
            if (state_q == PACK_SEND)
               overflow_o <= 1'b1;               // frame lost
         end
         case (state_q)
            PACK_EMPTY: begin
               if (frame_done_i) begin
                  state_q  <= PACK_SEND;         // valid next cycle
                  word_idx <= '0;
               end
            end
            PACK_SEND: begin
               if (m_axis_tready_i) begin
                  if (word_idx == LAST_WORD) begin
                     state_q  <= PACK_EMPTY;
                     word_idx <= '0;
                  end else begin
                     word_idx <= word_idx + 1'b1;
                  end
               end
            end
            default: state_q <= PACK_EMPTY;
         endcase
      end
   end

   // frame payload
   always_ff @(posedge adc_read_clk) begin
      if (capture) begin
         frame_buf <= samples_i;
         buf_seq   <= frame_seq_q;
      end
   end

   // **************************************************
   // slot formatting
   // **************************************************
   // slot k of word w is channel w*4+k, slot 0 in the low bits
   always_comb begin
      int ch;
      m_axis_tdata_o = '0;
      for (int k = 0; k < SLOTS; k++) begin
         ch = int'(word_idx) * SLOTS + k;
         m_axis_tdata_o[k*SLOT_W +: SLOT_W] = {buf_seq, chan_idx_t'(ch), frame_buf[ch]};
      end
   end

   assign m_axis_tvalid_o = (state_q == PACK_SEND);
   assign m_axis_tlast_o  = m_axis_tvalid_o && (word_idx == LAST_WORD);   // end of frame

   // stalled word holds until taken
   a_stall_hold: assert property (@(posedge adc_read_clk) disable iff (!control_reg_i)
      m_axis_tvalid_o && !m_axis_tready_i |=>
         m_axis_tvalid_o && $stable(m_axis_tdata_o) && $stable(m_axis_tlast_o));

   // a taken word without last is followed by the rest of its frame, last ends it
   a_last_valid: assert property (@(posedge adc_read_clk) disable iff (!control_reg_i)
      m_axis_tvalid_o && m_axis_tready_i |=> (m_axis_tvalid_o == !$past(m_axis_tlast_o)));

endmodule
